// File: Makefile
# Verilator build, run and lint for the pipelined 16x16 multiplier

VERILATOR  ?= verilator
TOP        := tb_mul16_pipe
LINT_TOP   := mul16_pipe
FILELIST   := mul16_pipe.f
OBJ_DIR    := obj_dir
LOG        := sim.log
FAIL_MSG   := Simulation finished: FAIL
PASS_MSG   := Simulation finished: PASS

VFLAGS     := --binary --assert -j 0 --Mdir $(OBJ_DIR)
LINT_FLAGS := --lint-only --timing -Wall

SOURCES    := $(shell cat $(FILELIST))

.PHONY: all build run lint clean

all: run

build: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
	  echo "Simulation failed, see $(LOG)"; exit 1; \
	fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then \
	  echo "Simulation ended without a result, see $(LOG)"; exit 1; \
	fi

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(LINT_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: mul16_pipe.f
src/mul16_pkg.sv
src/mul8_array.sv
src/cla_adder.sv
src/partial_product_stage.sv
src/sum_stage.sv
src/mul16_pipe.sv
verification/tb_mul16_pipe.sv

// File: src/cla_adder.sv
/*
  Combinational 32-bit carry-lookahead adder built from 4-bit groups.
  Group propagate and generate terms feed a flat lookahead carry for
  every group. Carry-in is zero and no carry-out is produced.
*/
module cla_adder (
  input  mul16_pkg::product_t a,
  input  mul16_pkg::product_t b,
  output mul16_pkg::product_t sum
);

  import mul16_pkg::*;

  // Bit level terms; the top generate would only feed a carry-out
  logic [PRODUCT_W-1:0] bit_p;
  logic [PRODUCT_W-2:0] bit_g;

  // Group level terms, trimmed to what the group carries need
  logic [CLA_GROUPS-2:0] grp_g;
  logic [CLA_GROUPS-2:1] grp_p;
  logic [CLA_GROUPS-1:0] grp_c;

  assign bit_p = a ^ b;
  assign bit_g = a[PRODUCT_W-2:0] & b[PRODUCT_W-2:0];

  for (genvar k = 0; k < CLA_GROUPS; k++) begin : g_group
    localparam int LSB = k * CLA_GROUP_W;

    logic [CLA_GROUP_W-1:0] c_bit;

    if (k < CLA_GROUPS - 1) begin : g_gen
      assign grp_g[k] = bit_g[LSB+3]
                      | (bit_p[LSB+3] & bit_g[LSB+2])
                      | (bit_p[LSB+3] & bit_p[LSB+2] & bit_g[LSB+1])
                      | (bit_p[LSB+3] & bit_p[LSB+2] & bit_p[LSB+1] & bit_g[LSB]);
    end

    if (k > 0 && k < CLA_GROUPS - 1) begin : g_prop
      assign grp_p[k] = &bit_p[LSB +: CLA_GROUP_W];
    end

    // Carries inside the group, all from the group carry-in
    assign c_bit[0] = grp_c[k];
    assign c_bit[1] = bit_g[LSB]
                    | (bit_p[LSB] & grp_c[k]);
    assign c_bit[2] = bit_g[LSB+1]
                    | (bit_p[LSB+1] & bit_g[LSB])
                    | (bit_p[LSB+1] & bit_p[LSB] & grp_c[k]);
    assign c_bit[3] = bit_g[LSB+2]
                    | (bit_p[LSB+2] & bit_g[LSB+1])
                    | (bit_p[LSB+2] & bit_p[LSB+1] & bit_g[LSB])
                    | (bit_p[LSB+2] & bit_p[LSB+1] & bit_p[LSB] & grp_c[k]);

    assign sum[LSB +: CLA_GROUP_W] = bit_p[LSB +: CLA_GROUP_W] ^ c_bit;
  end

  // Lookahead across groups, sum of products over all lower generates
  always_comb begin
    logic term;
    logic carry;

    grp_c = '0;
    for (int k = 1; k < CLA_GROUPS; k++) begin
      carry = 1'b0;
      for (int m = 0; m < k; m++) begin
        term = grp_g[m];
        for (int n = m + 1; n < k; n++) begin
          term = term & grp_p[n];
        end
        carry = carry | term;
      end
      grp_c[k] = carry;
    end
  end

endmodule

// File: src/mul16_pipe.sv
/*
  Top level of the two-stage 16x16 unsigned multiplier.
  Operands enter with valid/ready, the product leaves two cycles later
  when the output is not stalled.
*/
module mul16_pipe (
  input  logic                     clk,
  input  logic                     rst_n,
  input  mul16_pkg::operand_pair_t operands,
  input  logic                     in_valid,
  output logic                     in_ready,
  output mul16_pkg::product_t      product,
  output logic                     out_valid,
  input  logic                     out_ready
);

  import mul16_pkg::*;

  // Link between the two stages
  partial_products_t pps;
  logic              pps_valid;
  logic              pps_ready;

  partial_product_stage u_pp_stage (
    .clk       (clk),
    .rst_n     (rst_n),
    .operands  (operands),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .pps       (pps),
    .pps_valid (pps_valid),
    .pps_ready (pps_ready)
  );

  sum_stage u_sum_stage (
    .clk       (clk),
    .rst_n     (rst_n),
    .pps       (pps),
    .pps_valid (pps_valid),
    .pps_ready (pps_ready),
    .product   (product),
    .out_valid (out_valid),
    .out_ready (out_ready)
  );

endmodule

// File: src/mul16_pkg.sv
/*
  Shared widths, vector types and bundled structs for the pipelined
  16x16 unsigned multiplier. Every design unit imports what it needs
  from here.
*/
package mul16_pkg;

  // Operand split into two halves
  localparam int OPERAND_W = 16;
  localparam int HALF_W    = 8;

  // Full product, also the adder width
  localparam int PRODUCT_W = 32;

  // Carry-lookahead grouping
  localparam int CLA_GROUP_W = 4;
  localparam int CLA_GROUPS  = PRODUCT_W / CLA_GROUP_W;

  typedef logic [OPERAND_W-1:0]  operand_t;
  typedef logic [HALF_W-1:0]     half_t;
  typedef logic [2*HALF_W-1:0]   pp_t;
  typedef logic [PRODUCT_W-1:0]  product_t;

  // Input side payload
  typedef struct packed {
    operand_t a;
    operand_t b;
  } operand_pair_t;

  // The four 8x8 sub-products, named by which halves of a and b they use
  typedef struct packed {
    pp_t ll;
    pp_t lh;
    pp_t hl;
    pp_t hh;
  } partial_products_t;

endpackage

// File: src/mul8_array.sv
/*
  Combinational 8x8 unsigned array multiplier.
  AND matrix reduced row by row with half and full adders, then a final
  row add of the last carry and sum vectors forms the upper byte.
*/
module mul8_array (
  input  mul16_pkg::half_t a,
  input  mul16_pkg::half_t b,
  output mul16_pkg::pp_t   p
);

  import mul16_pkg::*;

  // pp_bit[i][j] = a[i] & b[j]
  logic [HALF_W-1:0][HALF_W-1:0] pp_bit;

  for (genvar i = 0; i < HALF_W; i++) begin : g_and
    assign pp_bit[i] = b & {HALF_W{a[i]}};
  end

  // Row 0 is the plain AND row, its LSB is already final
  assign p[0] = pp_bit[0][0];

  for (genvar i = 1; i < HALF_W; i++) begin : g_row
    logic [HALF_W-1:0] row_sum;
    logic [HALF_W-2:0] row_carry;

    for (genvar j = 0; j < HALF_W - 1; j++) begin : g_cell
      if (i == 1) begin : g_half
        // First reduction row has no incoming carries
        assign row_sum[j]   = pp_bit[0][j+1] ^ pp_bit[1][j];
        assign row_carry[j] = pp_bit[0][j+1] & pp_bit[1][j];
      end else begin : g_full
        logic x;
        logic y;
        logic cin;

        assign x   = g_row[i-1].row_sum[j+1];
        assign y   = pp_bit[i][j];
        assign cin = g_row[i-1].row_carry[j];

        assign row_sum[j]   = x ^ y ^ cin;
        assign row_carry[j] = (x & y) | (x & cin) | (y & cin);
      end
    end

    // Top bit of each row passes straight down
    assign row_sum[HALF_W-1] = pp_bit[i][HALF_W-1];

    assign p[i] = row_sum[0];
  end

  // Final row adder, carries line up under the sums one column left
  assign p[2*HALF_W-1:HALF_W] = {1'b0, g_row[HALF_W-1].row_carry}
                              + {1'b0, g_row[HALF_W-1].row_sum[HALF_W-1:1]};

endmodule

// File: src/partial_product_stage.sv
/*
  First pipeline stage of the 16x16 multiplier.
  Splits both operands into halves, forms the four 8x8 sub-products and
  registers them behind a valid/ready handshake.
*/
module partial_product_stage (
  input  logic                         clk,
  input  logic                         rst_n,
  input  mul16_pkg::operand_pair_t     operands,
  input  logic                         in_valid,
  output logic                         in_ready,
  output mul16_pkg::partial_products_t pps,
  output logic                         pps_valid,
  input  logic                         pps_ready
);

  import mul16_pkg::*;

  half_t             a_lo;
  half_t             a_hi;
  half_t             b_lo;
  half_t             b_hi;
  partial_products_t pps_next;
  logic              take;

  assign a_lo = operands.a[HALF_W-1:0];
  assign a_hi = operands.a[OPERAND_W-1:HALF_W];
  assign b_lo = operands.b[HALF_W-1:0];
  assign b_hi = operands.b[OPERAND_W-1:HALF_W];

  mul8_array u_mul_ll (.a(a_lo), .b(b_lo), .p(pps_next.ll));
  mul8_array u_mul_lh (.a(a_lo), .b(b_hi), .p(pps_next.lh));
  mul8_array u_mul_hl (.a(a_hi), .b(b_lo), .p(pps_next.hl));
  mul8_array u_mul_hh (.a(a_hi), .b(b_hi), .p(pps_next.hh));

  // Register free, or being drained this cycle
  assign in_ready = !pps_valid || pps_ready;
  assign take     = in_valid && in_ready;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pps_valid <= 1'b0;
    end else if (in_ready) begin
      pps_valid <= in_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (take) begin
      pps <= pps_next;
    end
  end

  // Stalled output must not change under the sum stage
  a_pps_hold: assert property (@(posedge clk) disable iff (!rst_n)
    pps_valid && !pps_ready |=> pps_valid && $stable(pps));

endmodule

// File: src/sum_stage.sv
/*
  Second pipeline stage of the 16x16 multiplier.
  Places hh over ll, adds the two cross products shifted up one byte in
  two carry-lookahead passes, and registers the exact product.
*/
module sum_stage (
  input  logic                         clk,
  input  logic                         rst_n,
  input  mul16_pkg::partial_products_t pps,
  input  logic                         pps_valid,
  output logic                         pps_ready,
  output mul16_pkg::product_t          product,
  output logic                         out_valid,
  input  logic                         out_ready
);

  import mul16_pkg::*;

  product_t llhh;
  product_t cross_lh;
  product_t cross_hl;
  product_t sum_lh;
  product_t sum_all;
  logic     take;

  // ll and hh never overlap, so they share one word
  assign llhh     = {pps.hh, pps.ll};
  assign cross_lh = {{HALF_W{1'b0}}, pps.lh, {HALF_W{1'b0}}};
  assign cross_hl = {{HALF_W{1'b0}}, pps.hl, {HALF_W{1'b0}}};

  cla_adder u_add_cross_lh (
    .a   (llhh),
    .b   (cross_lh),
    .sum (sum_lh)
  );

  cla_adder u_add_cross_hl (
    .a   (sum_lh),
    .b   (cross_hl),
    .sum (sum_all)
  );

  assign pps_ready = !out_valid || out_ready;
  assign take      = pps_valid && pps_ready;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      out_valid <= 1'b0;
    end else if (pps_ready) begin
      out_valid <= pps_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (take) begin
      product <= sum_all;
    end
  end

  a_product_hold: assert property (@(posedge clk) disable iff (!rst_n)
    out_valid && !out_ready |=> out_valid && $stable(product));

  a_valid_known: assert property (@(posedge clk) disable iff (!rst_n)
    !$isunknown(out_valid));

endmodule

// File: verification/tb_mul16_pipe.sv
/*
  Testbench for the two-stage 16x16 unsigned multiplier.
  Sends corner and random operand pairs through the valid/ready handshake
  with random output stalls, then a back-to-back burst, and checks every
  product and its order against a queue model of the true product.
*/
module tb_mul16_pipe;

  import mul16_pkg::*;

  localparam int CLK_HALF     = 20;
  localparam int DRIVE_DELAY  = 2;
  localparam int RESET_CYCLES = 5;
  localparam int RAND_SEED    = 88583;
  localparam int RANDOM_PAIRS = 4000;
  localparam int BURST_PAIRS  = 64;
  localparam int ACCEPT_LIMIT = 100;
  localparam int DRAIN_LIMIT  = 100;
  localparam int NUM_CORNERS  = 6;

  logic          clk;
  logic          rst_n;
  operand_pair_t operands;
  logic          in_valid;
  logic          in_ready;
  product_t      product;
  logic          out_valid;
  logic          out_ready;

  // Expected products and the cycle each input was taken, in input order
  product_t      expect_q[$];
  int            in_cycle_q[$];

  int            cycle_cnt = 0;
  int            out_count = 0;
  logic          in_fire = 1'b0;
  logic          random_ready;
  logic          burst_check;
  logic          stalled = 1'b0;
  product_t      stalled_product;

  // Byte boundary and lookahead carry corners
  operand_t corners [NUM_CORNERS] = '{
    16'h0000, 16'h0001, 16'h00ff, 16'hff00, 16'h8000, 16'hffff
  };

  mul16_pipe u_mul16_pipe (
    .clk       (clk),
    .rst_n     (rst_n),
    .operands  (operands),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .product   (product),
    .out_valid (out_valid),
    .out_ready (out_ready)
  );

  always #CLK_HALF clk = ~clk;

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
  end

  task automatic stop_run();
    $display("Simulation finished: FAIL");
    $fatal(1, "Run stopped at the first error");
  endtask

  task automatic check_equal(input product_t actual, input product_t expected,
                             input string what);
    if (actual !== expected) begin
      $display("Fail at time %0t: %s, got 0x%08h, expected 0x%08h",
               $time, what, actual, expected);
      stop_run();
    end
  endtask

  // Monitor samples mid-cycle, when DUT outputs and driven inputs are settled
  always @(negedge clk) begin : monitor
    product_t expected;
    int       latency;

    if (rst_n) begin
      if (stalled) begin
        check_equal(32'(out_valid), 32'd1, "out_valid dropped while stalled");
        check_equal(product, stalled_product, "product changed while stalled");
      end
      stalled         = out_valid && !out_ready;
      stalled_product = product;

      in_fire = in_valid && in_ready;
      if (in_fire) begin
        expect_q.push_back(product_t'(operands.a) * product_t'(operands.b));
        in_cycle_q.push_back(cycle_cnt);
      end

      if (burst_check && in_valid) begin
        check_equal(32'(in_ready), 32'd1, "in_ready low during burst");
      end

      if (out_valid && out_ready) begin
        if (expect_q.size() == 0) begin
          $display("Error at time %0t: product delivered with no input waiting for it",
                   $time);
          stop_run();
        end else begin
          expected = expect_q.pop_front();
          latency  = cycle_cnt - in_cycle_q.pop_front();
          check_equal(product, expected, $sformatf("product of input %0d", out_count));
          if (burst_check) begin
            check_equal(32'(latency), 32'd2, "latency during burst");
          end
          out_count++;
        end
      end
    end else begin
      stalled = 1'b0;
      in_fire = 1'b0;
    end
  end

  // Advance one cycle, new inputs land just after the edge
  task automatic next_cycle();
    @(posedge clk);
    #DRIVE_DELAY;
    out_ready = random_ready ? ($urandom_range(0, 3) != 0) : 1'b1;
  endtask

  task automatic send_pair(input operand_t a, input operand_t b, input int max_gap);
    int gap;
    int waited;

    gap      = $urandom_range(0, max_gap);
    in_valid = 1'b0;
    repeat (gap) next_cycle();

    operands.a = a;
    operands.b = b;
    in_valid   = 1'b1;
    waited     = 0;
    do begin
      next_cycle();
      waited++;
    end while (!in_fire && waited < ACCEPT_LIMIT);

    if (!in_fire) begin
      $display("Timeout: operand pair not accepted within %0d cycles", ACCEPT_LIMIT);
      stop_run();
    end
    in_valid = 1'b0;
  endtask

  task automatic drain_model();
    int waited;

    in_valid     = 1'b0;
    random_ready = 1'b0;
    waited       = 0;
    while (expect_q.size() != 0 && waited < DRAIN_LIMIT) begin
      next_cycle();
      waited++;
    end

    if (expect_q.size() != 0) begin
      $display("Timeout: %0d products still missing after %0d cycles",
               expect_q.size(), DRAIN_LIMIT);
      stop_run();
    end
  endtask

  // Mostly random, now and then a corner value
  function automatic operand_t pick_operand();
    if ($urandom_range(0, 7) == 0) begin
      return corners[$urandom_range(0, NUM_CORNERS - 1)];
    end
    return operand_t'($urandom());
  endfunction

  initial begin : stimulus
    operand_t    a;
    operand_t    b;

    clk          = 1'b0;
    rst_n        = 1'b0;
    operands     = '0;
    in_valid     = 1'b0;
    out_ready    = 1'b0;
    random_ready = 1'b0;
    burst_check  = 1'b0;
    void'($urandom(RAND_SEED));

    repeat (RESET_CYCLES) @(posedge clk);
    #DRIVE_DELAY;
    rst_n = 1'b1;

    // Idle state right after reset, before any input
    @(negedge clk);
    check_equal(32'(out_valid), 32'd0, "out_valid high after reset");
    check_equal(32'(in_ready), 32'd1, "in_ready low after reset");
    next_cycle();

    // All corner pairings under random stalls
    random_ready = 1'b1;
    foreach (corners[i]) begin
      foreach (corners[j]) begin
        send_pair(corners[i], corners[j], 1);
      end
    end

    for (int n = 0; n < RANDOM_PAIRS; n++) begin
      a = pick_operand();
      b = pick_operand();
      send_pair(a, b, 2);
    end
    drain_model();

    // Back-to-back burst into an empty pipeline with the output always ready
    burst_check = 1'b1;
    for (int n = 0; n < BURST_PAIRS; n++) begin
      send_pair(operand_t'($urandom()), operand_t'($urandom()), 0);
    end
    drain_model();
    burst_check = 1'b0;

    // Every product is out, so nothing may be left in flight
    check_equal(32'(out_valid), 32'd0, "out_valid high with no input outstanding");
    $display("Simulation finished: PASS");
    $finish;
  end

endmodule
